/* source/board_pkg.sv */
package board_pkg;

  // bus word and byte address
  localparam int data_w = 16;
  localparam int addr_w = 8;
  localparam int strb_w = data_w / 8;

  // data RAM, byte addresses 0x00 to 0x7f
  localparam int ram_words = 64;
  localparam int ram_idx_w = $clog2(ram_words);

  // I/O words, bit 0 of an address is ignored
  localparam logic [addr_w-1:0] io_led_lcd_addr = 8'h80;
  localparam logic [addr_w-1:0] io_gpio_addr = 8'h82;

  // LED matrix geometry and row timing
  localparam int scan_rows = 6;
  localparam int row_w = $clog2(scan_rows);
  localparam int cnt_w = 16;
  localparam int scan_period_default = 27000;
  localparam int gap_on_default = 100;
  localparam int gap_off_default = 2000;

  // seven segments, msb first
  //      6
  //  1 |~~~| 5
  //    |-0-|
  //  2 |___| 4
  //      3
  // the dot is appended as the lowest bit of the column byte
  localparam int seg_w = 7;
  localparam logic [seg_w-1:0] seg_table [16] = '{
    7'b1111110, 7'b0110000, 7'b1101101, 7'b1111001,
    7'b0110011, 7'b1011011, 7'b1011111, 7'b1110010,
    7'b1111111, 7'b1111011, 7'b1110111, 7'b0011111,
    7'b1001110, 7'b0111101, 7'b1001111, 7'b1000111
  };

endpackage

/* source/bus_pkg.sv */
package bus_pkg;

  // APB request from the external CPU
  typedef struct packed {
    logic                                psel;
    logic                                penable;
    logic                                pwrite;
    logic [board_pkg::addr_w-1:0]        paddr;
    logic [board_pkg::data_w-1:0]        pwdata;
    logic [board_pkg::strb_w-1:0]        pstrb;
  } apb_req_t;

  typedef struct packed {
    logic [board_pkg::data_w-1:0]        prdata;
    logic                                pready;
    logic                                pslverr;
  } apb_rsp_t;

  // last accepted write, addr has bit 0 cleared
  typedef struct packed {
    logic [board_pkg::addr_w-1:0]        addr;
    logic [board_pkg::data_w-1:0]        data;
  } wr_trace_t;

  // a zero byte enable means no write
  typedef struct packed {
    logic [board_pkg::ram_idx_w-1:0]     index;
    logic [board_pkg::data_w-1:0]        data;
    logic [board_pkg::strb_w-1:0]        be;
  } ram_wr_t;

  // sel low picks the LED/LCD word, sel high the GPIO word
  typedef struct packed {
    logic                                sel;
    logic [board_pkg::data_w-1:0]        data;
    logic [board_pkg::strb_w-1:0]        be;
  } io_wr_t;

  typedef enum logic [1:0] {
    rgn_ram,
    rgn_io,
    rgn_rsv
  } region_t;

endpackage

/* source/data_ram.sv */
`timescale 1ns/1ps

module data_ram (
  input  logic                            sys_clk,
  input  bus_pkg::ram_wr_t                ram_wr,
  input  logic [board_pkg::ram_idx_w-1:0] rd_index,
  output logic [board_pkg::data_w-1:0]    rd_data
);
  import board_pkg::*;
  import bus_pkg::*;

  logic [data_w-1:0] mem [ram_words];

  // byte lanes written independently
  always_ff @(posedge sys_clk) begin
    for (int lane = 0; lane < strb_w; lane++) begin
      if (ram_wr.be[lane]) begin
        mem[ram_wr.index][lane*8 +: 8] <= ram_wr.data[lane*8 +: 8];
      end
    end
  end

  // registered read port, block RAM style
  always_ff @(posedge sys_clk) begin
    rd_data <= mem[rd_index];
  end

endmodule

/* source/io_regs.sv */
`timescale 1ns/1ps

module io_regs (
  input  logic                            sys_clk,
  input  logic                            rst_n,
  input  bus_pkg::io_wr_t                 io_wr,
  input  logic [board_pkg::ram_idx_w-1:0] rd_index,
  output logic [board_pkg::data_w-1:0]    rd_data,
  output logic [7:0]                      led,
  output logic [7:0]                      lcd,
  output logic [7:0]                      gpio
);
  import board_pkg::*;
  import bus_pkg::*;

  // output bytes, written per lane
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      led  <= '0;
      lcd  <= '0;
      gpio <= '0;
    end else if (io_wr.sel) begin
      // high lane of the GPIO word has no register
      if (io_wr.be[0]) begin
        gpio <= io_wr.data[7:0];
      end
    end else begin
      if (io_wr.be[0]) begin
        led <= io_wr.data[7:0];
      end
      if (io_wr.be[1]) begin
        lcd <= io_wr.data[15:8];
      end
    end
  end

  // read back, one cycle after the index
  always_ff @(posedge sys_clk) begin
    case (rd_index)
      io_led_lcd_addr[ram_idx_w:1]: rd_data <= {lcd, led};
      io_gpio_addr[ram_idx_w:1]:    rd_data <= {8'h00, gpio};
      default:                      rd_data <= '0;
    endcase
  end

endmodule

/* source/bus_fabric.sv */
`timescale 1ns/1ps

module bus_fabric (
  input  logic                            sys_clk,
  input  logic                            rst_n,
  input  bus_pkg::apb_req_t               apb_req,
  output bus_pkg::apb_rsp_t               apb_rsp,
  output bus_pkg::ram_wr_t                ram_wr,
  output bus_pkg::io_wr_t                 io_wr,
  output logic [board_pkg::ram_idx_w-1:0] rd_index,
  input  logic [board_pkg::data_w-1:0]    ram_rd_data,
  input  logic [board_pkg::data_w-1:0]    io_rd_data,
  output bus_pkg::wr_trace_t              wr_trace
);
  import board_pkg::*;
  import bus_pkg::*;

  logic [addr_w-1:0] word_addr;
  region_t           region;
  region_t           region_q;
  logic              access;
  logic              wr_accept;
  logic              rd_wait;

  assign word_addr = {apb_req.paddr[addr_w-1:1], 1'b0};
  assign access    = apb_req.psel & apb_req.penable;
  assign wr_accept = access & apb_req.pwrite;

  // address decode
  always_comb begin
    if (!word_addr[addr_w-1]) begin
      region = rgn_ram;
    end else if (word_addr == io_led_lcd_addr || word_addr == io_gpio_addr) begin
      region = rgn_io;
    end else begin
      region = rgn_rsv;
    end
  end

  // high during the second access cycle of a read
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_wait <= 1'b0;
    end else begin
      rd_wait <= access & ~apb_req.pwrite & ~rd_wait;
    end
  end

  // region of the transfer, taken from the setup cycle on
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      region_q <= rgn_rsv;
    end else if (apb_req.psel && !rd_wait) begin
      region_q <= region;
    end
  end

  always_comb begin
    apb_rsp.pready  = access & (apb_req.pwrite | rd_wait);
    apb_rsp.pslverr = apb_rsp.pready & (region == rgn_rsv);
    case (region_q)
      rgn_ram: apb_rsp.prdata = ram_rd_data;
      rgn_io:  apb_rsp.prdata = io_rd_data;
      default: apb_rsp.prdata = '0;
    endcase
  end

  // both blocks see the same word index
  assign rd_index = apb_req.paddr[ram_idx_w:1];

  // write strobes, one cycle wide
  assign ram_wr.index = apb_req.paddr[ram_idx_w:1];
  assign ram_wr.data  = apb_req.pwdata;
  assign ram_wr.be    = (wr_accept && region == rgn_ram) ? apb_req.pstrb : '0;

  assign io_wr.sel  = apb_req.paddr[1];
  assign io_wr.data = apb_req.pwdata;
  assign io_wr.be   = (wr_accept && region == rgn_io) ? apb_req.pstrb : '0;

  // last write for the LED display
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_trace <= '0;
    end else if (wr_accept && region != rgn_rsv) begin
      wr_trace.addr <= word_addr;
      wr_trace.data <= apb_req.pwdata;
    end
  end

endmodule

/* source/led_matrix_scan.sv */
`timescale 1ns/1ps

module led_matrix_scan #(
  parameter int unsigned scan_period = board_pkg::scan_period_default,
  parameter int unsigned gap_on      = board_pkg::gap_on_default,
  parameter int unsigned gap_off     = board_pkg::gap_off_default
) (
  input  logic                            sys_clk,
  input  logic                            rst_n,
  input  logic [7:0]                      led,
  input  logic [7:0]                      lcd,
  input  logic [7:0]                      gpio,
  input  bus_pkg::wr_trace_t              wr_trace,
  output logic [7:0]                      led_col,
  output logic [board_pkg::scan_rows-1:0] led_row
);
  import board_pkg::*;
  import bus_pkg::*;

  logic [cnt_w-1:0] counter;
  logic [row_w-1:0] row_idx;
  logic             cnt_wrap;
  logic             row_on;
  logic [3:0]       digit;

  assign cnt_wrap = (counter >= cnt_w'(scan_period - 1));

  // cycles within the current row
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      counter <= '0;
    end else if (cnt_wrap) begin
      counter <= '0;
    end else begin
      counter <= counter + 1'b1;
    end
  end

  // next row on counter wrap
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      row_idx <= '0;
    end else if (cnt_wrap) begin
      if (row_idx == row_w'(scan_rows - 1)) begin
        row_idx <= '0;
      end else begin
        row_idx <= row_idx + 1'b1;
      end
    end
  end

  // dark at both ends of a row so neighbours never overlap
  assign row_on = (counter >= cnt_w'(gap_on)) &&
                  (counter < cnt_w'(scan_period - gap_off));

  // rows are active low
  assign led_row = ~(scan_rows'(row_on) << row_idx);

  // hex digit of the traced word address
  assign digit = wr_trace.addr[4:1];

  always_comb begin
    case (row_idx)
      3'd0:    led_col = led;
      3'd1:    led_col = lcd;
      3'd2:    led_col = gpio;
      3'd3:    led_col = wr_trace.data[15:8];
      3'd4:    led_col = wr_trace.data[7:0];
      3'd5:    led_col = {seg_table[digit], wr_trace.addr[5]};
      default: led_col = 8'h00;
    endcase
  end

endmodule

/* source/board_io_top.sv */
`timescale 1ns/1ps

module board_io_top #(
  parameter int unsigned scan_period = board_pkg::scan_period_default,
  parameter int unsigned gap_on      = board_pkg::gap_on_default,
  parameter int unsigned gap_off     = board_pkg::gap_off_default
) (
  input  logic                            sys_clk,
  input  logic                            rst_n,
  input  bus_pkg::apb_req_t               apb_req,
  output bus_pkg::apb_rsp_t               apb_rsp,
  output logic [7:0]                      led_col,
  output logic [board_pkg::scan_rows-1:0] led_row,
  output logic                            lcd_e,
  output logic                            lcd_rw,
  output logic                            lcd_rs,
  output logic [3:0]                      lcd_db,
  output logic [7:0]                      gpio
);
  import board_pkg::*;
  import bus_pkg::*;

  ram_wr_t              ram_wr;
  io_wr_t               io_wr;
  wr_trace_t            wr_trace;
  logic [ram_idx_w-1:0] rd_index;
  logic [data_w-1:0]    ram_rd_data;
  logic [data_w-1:0]    io_rd_data;
  logic [7:0]           led;
  logic [7:0]           lcd;

  bus_fabric fabric_i (
    .sys_clk     (sys_clk),
    .rst_n       (rst_n),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .ram_wr      (ram_wr),
    .io_wr       (io_wr),
    .rd_index    (rd_index),
    .ram_rd_data (ram_rd_data),
    .io_rd_data  (io_rd_data),
    .wr_trace    (wr_trace)
  );

  data_ram ram_i (
    .sys_clk  (sys_clk),
    .ram_wr   (ram_wr),
    .rd_index (rd_index),
    .rd_data  (ram_rd_data)
  );

  io_regs regs_i (
    .sys_clk  (sys_clk),
    .rst_n    (rst_n),
    .io_wr    (io_wr),
    .rd_index (rd_index),
    .rd_data  (io_rd_data),
    .led      (led),
    .lcd      (lcd),
    .gpio     (gpio)
  );

  led_matrix_scan #(
    .scan_period (scan_period),
    .gap_on      (gap_on),
    .gap_off     (gap_off)
  ) scan_i (
    .sys_clk  (sys_clk),
    .rst_n    (rst_n),
    .led      (led),
    .lcd      (lcd),
    .gpio     (gpio),
    .wr_trace (wr_trace),
    .led_col  (led_col),
    .led_row  (led_row)
  );

  // LCD pins from the register byte, bit 3 has no pin
  assign lcd_e  = lcd[0];
  assign lcd_rw = lcd[1];
  assign lcd_rs = lcd[2];
  assign lcd_db = lcd[7:4];

endmodule

/* bench/board_io_props.sv */
`timescale 1ns/1ps

module board_io_props #(
  parameter int unsigned scan_period = board_pkg::scan_period_default,
  parameter int unsigned gap_on      = board_pkg::gap_on_default,
  parameter int unsigned gap_off     = board_pkg::gap_off_default
) (
  input logic                            sys_clk,
  input logic                            rst_n,
  input bus_pkg::apb_req_t               apb_req,
  input bus_pkg::apb_rsp_t               apb_rsp,
  input logic [7:0]                      led_col,
  input logic [board_pkg::scan_rows-1:0] led_row,
  input logic                            lcd_e,
  input logic                            lcd_rw,
  input logic                            lcd_rs,
  input logic [3:0]                      lcd_db,
  input logic [7:0]                      gpio
);
  import board_pkg::*;
  import bus_pkg::*;

  int unsigned          err_count;
  logic [data_w-1:0]    mem_s [ram_words];
  logic [strb_w-1:0]    known_s [ram_words];
  logic [7:0]           led_s;
  logic [7:0]           lcd_s;
  logic [7:0]           gpio_s;
  logic [addr_w-1:0]    trace_addr_s;
  logic [data_w-1:0]    trace_data_s;
  int unsigned          cnt_s;
  int unsigned          row_s;
  logic [ram_idx_w-1:0] idx;
  logic                 is_ram;
  logic                 is_led_lcd;
  logic                 is_gpio;
  logic                 mapped;
  logic                 setup;
  logic                 wr_now;
  logic                 rd_done;
  logic [data_w-1:0]    exp_rdata;
  logic [data_w-1:0]    rd_mask;
  logic [scan_rows-1:0] exp_row;
  logic [7:0]           exp_col;

  initial err_count = 0;

  task automatic record_failure(input string msg);
    err_count++;
    $error("MISMATCH %0t: %s", $time, msg);
  endtask

  // address map decode, bit 0 ignored
  assign idx        = apb_req.paddr[ram_idx_w:1];
  assign is_ram     = !apb_req.paddr[addr_w-1];
  assign is_led_lcd = apb_req.paddr[addr_w-1:1] == io_led_lcd_addr[addr_w-1:1];
  assign is_gpio    = apb_req.paddr[addr_w-1:1] == io_gpio_addr[addr_w-1:1];
  assign mapped     = is_ram | is_led_lcd | is_gpio;
  assign setup      = apb_req.psel & ~apb_req.penable;
  assign wr_now     = apb_req.psel & apb_req.penable & apb_req.pwrite & mapped;
  assign rd_done    = apb_req.psel & apb_req.penable & ~apb_req.pwrite & apb_rsp.pready;

  // shadow registers and trace, taken from completed writes
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      led_s        <= '0;
      lcd_s        <= '0;
      gpio_s       <= '0;
      trace_addr_s <= '0;
      trace_data_s <= '0;
      for (int i = 0; i < ram_words; i++) begin
        known_s[i] <= '0;
      end
    end else if (wr_now) begin
      trace_addr_s <= {apb_req.paddr[addr_w-1:1], 1'b0};
      trace_data_s <= apb_req.pwdata;
      if (is_ram) begin
        known_s[idx] <= known_s[idx] | apb_req.pstrb;
      end
      if (is_led_lcd && apb_req.pstrb[0]) begin
        led_s <= apb_req.pwdata[7:0];
      end
      if (is_led_lcd && apb_req.pstrb[1]) begin
        lcd_s <= apb_req.pwdata[15:8];
      end
      if (is_gpio && apb_req.pstrb[0]) begin
        gpio_s <= apb_req.pwdata[7:0];
      end
    end
  end

  // shadow RAM, lanes never written are masked on reads
  always @(posedge sys_clk) begin
    if (wr_now && is_ram) begin
      for (int lane = 0; lane < strb_w; lane++) begin
        if (apb_req.pstrb[lane]) begin
          mem_s[idx][lane*8 +: 8] <= apb_req.pwdata[lane*8 +: 8];
        end
      end
    end
  end

  always_comb begin
    exp_rdata = '0;
    rd_mask   = '1;
    if (is_ram) begin
      exp_rdata = mem_s[idx];
      rd_mask   = {{8{known_s[idx][1]}}, {8{known_s[idx][0]}}};
    end else if (is_led_lcd) begin
      exp_rdata = {lcd_s, led_s};
    end else if (is_gpio) begin
      exp_rdata = {8'h00, gpio_s};
    end
  end

  // reference row timing
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_s <= 0;
      row_s <= 0;
    end else if (cnt_s == scan_period - 1) begin
      cnt_s <= 0;
      row_s <= (row_s == scan_rows - 1) ? 0 : row_s + 1;
    end else begin
      cnt_s <= cnt_s + 1;
    end
  end

  assign exp_row = (cnt_s >= gap_on && cnt_s < scan_period - gap_off) ?
                   ~(scan_rows'(1) << row_s) : '1;

  always_comb begin
    case (row_s)
      0:       exp_col = led_s;
      1:       exp_col = lcd_s;
      2:       exp_col = gpio_s;
      3:       exp_col = trace_data_s[15:8];
      4:       exp_col = trace_data_s[7:0];
      default: exp_col = {seg_table[trace_addr_s[4:1]], trace_addr_s[5]};
    endcase
  end

  a_write_ready: assert property (@(posedge sys_clk) disable iff (!rst_n)
    setup && apb_req.pwrite |=> apb_rsp.pready)
    else record_failure("write not ready in its first access cycle");

  a_read_wait: assert property (@(posedge sys_clk) disable iff (!rst_n)
    setup && !apb_req.pwrite |=> !apb_rsp.pready ##1 apb_rsp.pready)
    else record_failure("read wait state wrong");

  a_ready_in_access: assert property (@(posedge sys_clk) disable iff (!rst_n)
    apb_rsp.pready |-> apb_req.psel && apb_req.penable)
    else record_failure("pready outside an access cycle");

  a_slverr_mapped: assert property (@(posedge sys_clk) disable iff (!rst_n)
    apb_rsp.pslverr |-> apb_rsp.pready && !mapped)
    else record_failure("pslverr on a mapped address");

  a_reserved: assert property (@(posedge sys_clk) disable iff (!rst_n)
    apb_rsp.pready && !mapped |-> apb_rsp.pslverr && apb_rsp.prdata == '0)
    else record_failure("reserved access response");

  a_read_data: assert property (@(posedge sys_clk) disable iff (!rst_n)
    rd_done && mapped |-> ((apb_rsp.prdata ^ exp_rdata) & rd_mask) == '0)
    else record_failure("read data differs from shadow");

  a_io_pins: assert property (@(posedge sys_clk) disable iff (!rst_n)
    gpio == gpio_s && {lcd_db, lcd_rs, lcd_rw, lcd_e} == {lcd_s[7:4], lcd_s[2:0]})
    else record_failure("gpio or LCD pins differ from shadow");

  a_row_single: assert property (@(posedge sys_clk) disable iff (!rst_n)
    $countones(~led_row) <= 1)
    else record_failure("more than one row driven");

  a_row_timing: assert property (@(posedge sys_clk) disable iff (!rst_n)
    led_row == exp_row)
    else record_failure("led_row differs from row timing");

  a_col_pattern: assert property (@(posedge sys_clk) disable iff (!rst_n)
    led_col == exp_col)
    else record_failure("led_col differs from row pattern");

  // during reset and on the first cycle out of it
  a_reset_state: assert property (@(posedge sys_clk)
    !rst_n || $rose(rst_n) |-> led_row == '1 && !apb_rsp.pready && gpio == '0 &&
                                {lcd_db, lcd_rs, lcd_rw, lcd_e} == '0)
    else record_failure("outputs not idle around reset");

endmodule

bind board_io_top board_io_props #(
  .scan_period (scan_period),
  .gap_on      (gap_on),
  .gap_off     (gap_off)
) props_i (
  .sys_clk (sys_clk),
  .rst_n   (rst_n),
  .apb_req (apb_req),
  .apb_rsp (apb_rsp),
  .led_col (led_col),
  .led_row (led_row),
  .lcd_e   (lcd_e),
  .lcd_rw  (lcd_rw),
  .lcd_rs  (lcd_rs),
  .lcd_db  (lcd_db),
  .gpio    (gpio)
);

/* bench/board_io_tb.sv */
`timescale 1ns/1ps

module board_io_tb;
  import board_pkg::*;
  import bus_pkg::*;

  localparam int n_transfers    = 400;
  localparam int scan_cycles    = 2000;
  localparam int timeout_cycles = n_transfers * 3 + scan_cycles + 50;

  logic                 sys_clk;
  logic                 rst_n;
  apb_req_t             apb_req;
  apb_rsp_t             apb_rsp;
  logic [7:0]           led_col;
  logic [scan_rows-1:0] led_row;
  logic                 lcd_e;
  logic                 lcd_rw;
  logic                 lcd_rs;
  logic [3:0]           lcd_db;
  logic [7:0]           gpio;
  logic [31:0]          lfsr_state;
  int                   cycle_count = 0;

  board_io_top #(
    .scan_period (40),
    .gap_on      (3),
    .gap_off     (6)
  ) dut_i (
    .sys_clk (sys_clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .led_col (led_col),
    .led_row (led_row),
    .lcd_e   (lcd_e),
    .lcd_rw  (lcd_rw),
    .lcd_rs  (lcd_rs),
    .lcd_db  (lcd_db),
    .gpio    (gpio)
  );

  initial begin
    sys_clk = 1'b0;
    forever #2 sys_clk = ~sys_clk;
  end

  // galois form, shifts right
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  // one LFSR step per bit taken
  task automatic take_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      value      = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // reserved picks land in 0x84 to 0xff
  function automatic logic [addr_w-1:0] pick_addr(input logic [2:0] kind, input logic [6:0] bits);
    case (kind)
      3'd4:    pick_addr = io_led_lcd_addr | {7'd0, bits[0]};
      3'd5:    pick_addr = io_gpio_addr | {7'd0, bits[0]};
      3'd6:    pick_addr = {1'b1, (bits < 7'h04) ? (bits | 7'h04) : bits};
      default: pick_addr = {1'b0, bits};
    endcase
  endfunction

  // setup cycle, then access cycles until pready
  task automatic apb_transfer(input logic write, input logic [addr_w-1:0] addr,
                              input logic [data_w-1:0] data, input logic [strb_w-1:0] strb);
    @(posedge sys_clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= write;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= data;
    apb_req.pstrb   <= strb;
    @(posedge sys_clk);
    apb_req.penable <= 1'b1;
    @(negedge sys_clk);
    while (!apb_rsp.pready) begin
      @(negedge sys_clk);
    end
  endtask

  initial begin
    logic [31:0] kind;
    logic [31:0] addr_bits;
    logic [31:0] data_bits;
    logic [31:0] strb_bits;
    logic [31:0] dir_bit;
    lfsr_state = 32'd93346;
    rst_n      = 1'b0;
    apb_req    = '0;
    repeat (4) @(posedge sys_clk);
    rst_n <= 1'b1;
    // fill the whole RAM first
    for (int i = 0; i < ram_words; i++) begin
      take_bits(data_w, data_bits);
      apb_transfer(1'b1, {1'b0, 6'(i), 1'b0}, data_bits[15:0], 2'b11);
    end
    for (int n = ram_words; n < n_transfers; n++) begin
      take_bits(3, kind);
      take_bits(7, addr_bits);
      take_bits(data_w, data_bits);
      take_bits(strb_w, strb_bits);
      take_bits(1, dir_bit);
      apb_transfer(dir_bit[0], pick_addr(kind[2:0], addr_bits[6:0]), data_bits[15:0],
                   strb_bits[1:0]);
    end
    @(posedge sys_clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
    // let the scanner run through several frames
    repeat (scan_cycles) @(posedge sys_clk);
    if (dut_i.props_i.err_count == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Test FAILED");
      $fatal(1, "assertion failures in the bound checker");
    end
  end

  // stop at the first failed assertion
  always @(negedge sys_clk) begin
    if (dut_i.props_i.err_count != 0) begin
      $display("Test FAILED");
      $fatal(1, "an assertion in the bound checker failed");
    end
  end

  always @(posedge sys_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Test FAILED");
      $fatal(1, "timeout, run did not finish within %0d cycles", timeout_cycles);
    end
  end

endmodule

/* vlog.f */
source/board_pkg.sv
source/bus_pkg.sv
source/data_ram.sv
source/io_regs.sv
source/bus_fabric.sv
source/led_matrix_scan.sv
source/board_io_top.sv
bench/board_io_props.sv
bench/board_io_tb.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the board I/O testbench
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal --top-module board_io_tb \
  -f vlog.f -o board_io_sim || { echo "build failed"; exit 1; }

# keep running past a failed assertion so the testbench reports it
./obj_dir/board_io_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

grep -q "Test FAILED" sim.log && { echo "simulation failed"; exit 1; } \
  || { echo "simulation passed"; exit 0; }
